// ==== filelist.f ====
common/eth_frame_pkg.sv
common/eth_crc_pkg.sv
rx_mac/rx_frame_parser.sv
rx_mac/rx_crc32.sv
rx_mac/rx_word_buffer.sv
rx_mac/rx_status_queue.sv
rx_mac/rx_deliver_ctrl.sv
source/eth_rx_top.sv
test/eth_rx_props.sv
test/tb_eth_rx.sv

// ==== Makefile ====
# Verilator simulation of the Ethernet receive path
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_eth_rx
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = tests failed
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_eth_rx.sv ====
// Ethernet receive path testbench
// Sends GMII frames with random payload, predicts the delivered words
// or drops, and checks them against the DUT under credit flow control
`timescale 1ns/1ps

module tb_eth_rx;
    import eth_frame_pkg::*;
    import eth_crc_pkg::*;

    localparam int DRIVE_DLY = 2;               // ns after the rising edge

    typedef logic [ETH_BYTE_W-1:0] byte_q_t [$];

    logic                  RxClk = 1'b0;
    logic                  rst_n;
    logic                  rx_valid;
    logic [ETH_BYTE_W-1:0] rx_data;
    logic                  rx_err;
    logic                  credit_return;
    logic                  word_valid;
    logic [ETH_WORD_W-1:0] word_data;
    logic                  word_last;
    logic [ETH_LEN_W-1:0]  frame_bytes;
    logic                  frame_dropped;

    logic [ETH_WORD_W-1:0] exp_words [$];       // Good frames only
    bit                    exp_last  [$];
    bit                    exp_drop  [$];       // One entry per frame
    logic [ETH_LEN_W-1:0]  exp_len   [$];
    logic [31:0]           lcg_state = 32'hafbf_774d;
    string                 test_name;
    int                    bytes_sent;
    int                    received;            // Words seen at the output
    int                    returned;            // Credits handed back
    int                    owed;                // Words not yet credited
    int                    credit_period;       // Cycles between credit pulses

    always #10 RxClk = ~RxClk;                  // 20 ns period

    eth_rx_top i_eth_rx_top (
        .RxClk, .rst_n, .rx_valid, .rx_data, .rx_err, .credit_return,
        .word_valid, .word_data, .word_last, .frame_bytes, .frame_dropped
    );

    bind rx_deliver_ctrl eth_rx_props i_eth_rx_props (
        .RxClk, .rst_n, .credit_return, .word_valid, .frame_dropped, .status_pop,
        .status_empty
    );

    // ------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick_even(input int lo);
        return lo + 2 * int'(next_random() % 32'd40);
    endfunction

    function automatic byte_q_t random_payload(input int n);
        byte_q_t     data;
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = next_random();
            data.push_back(r[23:16]);           // Upper bits spread better
        end
        return data;
    endfunction

    function automatic logic [CRC_W-1:0] crc_over(input byte_q_t data, input int n);
        logic [CRC_W-1:0] crc;
        crc = CRC_INIT;
        for (int i = 0; i < n; i++) begin
            crc = crc32_byte(crc, data[i]);
        end
        return crc;
    endfunction

    // Complemented register goes out bit 31 first, each byte LSB first on the wire
    function automatic logic [7:0] fcs_byte(input logic [CRC_W-1:0] crc, input int k);
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = ~crc[31 - 8 * k - i];
        end
        return b;
    endfunction

    function automatic byte_q_t with_fcs(input byte_q_t data);
        byte_q_t          frame;
        logic [CRC_W-1:0] crc;
        frame = data;
        crc   = crc_over(data, data.size());
        for (int k = 0; k < 4; k++) begin
            frame.push_back(fcs_byte(crc, k));
        end
        return frame;
    endfunction

    function automatic bit fcs_matches(input byte_q_t frame);
        logic [CRC_W-1:0] crc;
        int               n;
        bit               ok;
        n   = frame.size();
        crc = crc_over(frame, n - 4);
        ok  = 1'b1;
        for (int k = 0; k < 4; k++) begin
            if (frame[n - 4 + k] != fcs_byte(crc, k)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Expected outcome of one frame, and its words when it is good
    function automatic void predict_frame(input byte_q_t frame, input int pre_len,
                                          input bit phy_err);
        int         n;
        bit         bad;
        logic [7:0] hi;
        n   = frame.size();
        bad = (pre_len != ETH_PREAMBLE_LEN) || phy_err ||
              (n > int'(ETH_MAX_FRAME_BYTES)) || !fcs_matches(frame);
        exp_drop.push_back(bad);
        exp_len.push_back(ETH_LEN_W'(n));
        if (!bad) begin
            for (int i = 0; i < n; i += 2) begin
                hi = (i + 1 < n) ? frame[i + 1] : 8'h00;    // Odd tail padded
                exp_words.push_back({hi, frame[i]});
                exp_last.push_back(i + 2 >= n);
            end
        end
    endfunction

    // err_at is a data byte index, -1 for a clean frame
    task automatic send_frame(input byte_q_t frame, input int pre_len, input int err_at,
                              input int gap);
        predict_frame(frame, pre_len, err_at >= 0);
        for (int i = 0; i < pre_len + 1 + frame.size(); i++) begin
            @(posedge RxClk);
            #DRIVE_DLY;
            rx_valid = 1'b1;
            rx_err   = (i > pre_len) && (i - pre_len - 1 == err_at);
            if (i < pre_len) begin
                rx_data = ETH_PREAMBLE_BYTE;
            end else if (i == pre_len) begin
                rx_data = ETH_SFD_BYTE;
            end else begin
                rx_data = frame[i - pre_len - 1];
            end
            bytes_sent++;
        end
        repeat (gap) begin
            @(posedge RxClk);
            #DRIVE_DLY;
            rx_valid = 1'b0;
            rx_err   = 1'b0;
            rx_data  = '0;
        end
    endtask

    task automatic wait_drain();
        while (exp_drop.size() != 0) begin
            @(posedge RxClk);
        end
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic report_error(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic verify_word(input logic [ETH_WORD_W-1:0] exp,
                               input logic [ETH_WORD_W-1:0] act);
        if (act !== exp) begin
            report_error($sformatf("MISMATCH %s word: expected %h actual %h",
                                   test_name, exp, act));
        end
    endtask

    task automatic check_length(input logic [ETH_LEN_W-1:0] exp,
                                input logic [ETH_LEN_W-1:0] act);
        if (act !== exp) begin
            report_error($sformatf("MISMATCH %s frame_bytes: expected %0d actual %0d",
                                   test_name, exp, act));
        end
    endtask

    task automatic expect_flag(input string field, input logic exp, input logic act);
        if (act !== exp) begin
            report_error($sformatf("MISMATCH %s %s: expected %0b actual %0b",
                                   test_name, field, exp, act));
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge RxClk) begin : compare_outputs
        if (rst_n && word_valid && frame_dropped) begin
            report_error("word_valid and frame_dropped were high in the same cycle");
        end else if (rst_n && word_valid) begin
            received++;
            owed++;
            if (received > int'(CREDIT_MAX) + returned) begin
                report_error("more words received than credits granted");
            end else if (exp_words.size() == 0) begin
                report_error("word received while no good frame was expected");
            end else begin
                expect_flag("drop", exp_drop[0], 1'b0);
                verify_word(exp_words.pop_front(), word_data);
                expect_flag("last", exp_last.pop_front(), word_last);
                if (word_last) begin
                    check_length(exp_len.pop_front(), frame_bytes);
                    void'(exp_drop.pop_front());
                end
            end
        end else if (rst_n && frame_dropped) begin
            if (exp_drop.size() == 0) begin
                report_error("frame dropped while no frame was expected");
            end else begin
                expect_flag("drop", exp_drop.pop_front(), 1'b1);
                void'(exp_len.pop_front());
            end
        end
    end

    // Consumer hands back one credit per word, at most every credit_period cycles
    initial begin : return_credits
        int tick;
        tick = 0;
        forever begin
            @(posedge RxClk);
            #DRIVE_DLY;
            credit_return = 1'b0;
            tick++;
            if ((owed > 0) && (tick >= credit_period)) begin
                credit_return = 1'b1;
                owed--;
                returned++;
                tick = 0;
            end
        end
    end

    // Budget grows with every byte sent
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 40 * bytes_sent + 1000) begin
            @(posedge RxClk);
            cycles++;
        end
        report_error("timeout, the DUT stopped producing expected output");
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin : run_tests
        byte_q_t frame;
        rst_n         = 1'b0;
        rx_valid      = 1'b0;
        rx_data       = '0;
        rx_err        = 1'b0;
        credit_return = 1'b0;
        credit_period = 1;
        repeat (3) @(posedge RxClk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        test_name = "even_frame";
        send_frame(with_fcs(random_payload(pick_even(46))), ETH_PREAMBLE_LEN, -1, 12);
        wait_drain();
        test_name = "odd_frame";
        send_frame(with_fcs(random_payload(pick_even(46) + 1)), ETH_PREAMBLE_LEN, -1, 12);
        wait_drain();

        test_name = "bad_fcs";
        frame = with_fcs(random_payload(pick_even(60)));
        frame[frame.size() - 1] = frame[frame.size() - 1] ^ 8'h01;   // Broken FCS
        send_frame(frame, ETH_PREAMBLE_LEN, -1, 12);
        send_frame(with_fcs(random_payload(pick_even(50))), ETH_PREAMBLE_LEN, -1, 12);
        wait_drain();

        test_name = "short_preamble";
        send_frame(with_fcs(random_payload(64)), ETH_PREAMBLE_LEN - 1, -1, 12);
        wait_drain();
        test_name = "phy_error";
        send_frame(with_fcs(random_payload(64)), ETH_PREAMBLE_LEN, 20, 12);
        wait_drain();
        test_name = "too_long";
        send_frame(with_fcs(random_payload(int'(ETH_MAX_FRAME_BYTES) + 10)),
                   ETH_PREAMBLE_LEN, -1, 12);
        wait_drain();

        test_name     = "credit_throttle";
        credit_period = 5;                      // Slow consumer
        repeat (3) begin
            send_frame(with_fcs(random_payload(pick_even(40) + 1)), ETH_PREAMBLE_LEN, -1, 12);
        end
        wait_drain();
        credit_period = 1;

        test_name = "back_to_back";
        for (int i = 0; i < 6; i++) begin
            frame = with_fcs(random_payload(pick_even(46) + i % 2));
            if (i % 3 == 1) begin
                frame[5] = ~frame[5];           // Payload hit, FCS no longer matches
            end
            send_frame(frame, ETH_PREAMBLE_LEN, (i == 5) ? 9 : -1, 1);
        end
        wait_drain();

        repeat (20) @(posedge RxClk);           // Catch stray output
        if (exp_drop.size() == 0 && exp_words.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_error("expected output still pending at the end of the run");
        end
    end

endmodule

// ==== test/eth_rx_props.sv ====
// Delivery controller properties
// Credit limit, output exclusivity and status queue handshake
`timescale 1ns/1ps

module eth_rx_props (
    input logic RxClk,
    input logic rst_n,
    input logic credit_return,
    input logic word_valid,
    input logic frame_dropped,
    input logic status_pop,
    input logic status_empty
);

    // ------------------------------------------------------------------
    // Consumer side
    // ------------------------------------------------------------------
    int words_sent;     // Words taken by the consumer so far
    int credits_back;   // Credit pulses handed back so far

    // Running totals as the consumer sees them
    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            words_sent   <= 0;
            credits_back <= 0;
        end else begin
            if (word_valid) begin
                words_sent <= words_sent + 1;
            end
            if (credit_return) begin
                credits_back <= credits_back + 1;
            end
        end
    end

    no_word_without_credit: assert property (@(posedge RxClk) disable iff (!rst_n)
        word_valid |-> (words_sent < int'(eth_frame_pkg::CREDIT_MAX) + credits_back))
        else $error("word_valid raised with no consumer credit");

    // A frame is either delivered or dropped, never both in one cycle
    deliver_or_drop: assert property (@(posedge RxClk) disable iff (!rst_n)
        !(word_valid && frame_dropped))
        else $error("word_valid and frame_dropped high together");

    // Status queue side
    no_pop_when_empty: assert property (@(posedge RxClk) disable iff (!rst_n)
        status_pop |-> !status_empty)
        else $error("status record popped from an empty queue");

endmodule

// ==== source/eth_rx_top.sv ====
// Ethernet receive top level
// Parser, CRC check, word buffer and status queue feed the delivery
// controller, all on RxClk
`timescale 1ns/1ps

module eth_rx_top (
    input  logic                                 RxClk,
    input  logic                                 rst_n,
    input  logic                                 rx_valid,
    input  logic [eth_frame_pkg::ETH_BYTE_W-1:0] rx_data,
    input  logic                                 rx_err,
    input  logic                                 credit_return,
    output logic                                 word_valid,
    output logic [eth_frame_pkg::ETH_WORD_W-1:0] word_data,
    output logic                                 word_last,
    output logic [eth_frame_pkg::ETH_LEN_W-1:0]  frame_bytes,
    output logic                                 frame_dropped
);
    import eth_frame_pkg::*;

    // Parser to datapath
    logic                  byte_valid;
    logic                  sof;
    logic                  eof;
    logic                  preamble_error;
    logic                  phy_error;
    logic                  too_long;
    logic [ETH_BYTE_W-1:0] byte_data;
    logic [ETH_LEN_W-1:0]  frame_len;
    logic                  crc_error;

    // Datapath to controller
    logic                  status_empty;
    logic                  status_pop;
    logic [ETH_LEN_W-1:0]  head_len;
    logic                  head_bad;
    logic                  word_pop;
    logic [ETH_WORD_W-1:0] buf_word;

    rx_frame_parser i_rx_frame_parser (
        .RxClk, .rst_n, .rx_valid, .rx_err, .rx_data,
        .byte_valid, .sof, .eof, .preamble_error, .phy_error, .too_long,
        .byte_data, .frame_len
    );

    rx_crc32 i_rx_crc32 (
        .RxClk, .rst_n, .byte_valid, .sof, .byte_data, .crc_error
    );

    rx_word_buffer i_rx_word_buffer (
        .RxClk, .rst_n, .byte_valid, .eof, .word_pop, .byte_data, .buf_word
    );

    rx_status_queue i_rx_status_queue (
        .RxClk, .rst_n, .eof, .preamble_error, .phy_error, .too_long, .crc_error,
        .status_pop, .frame_len, .status_empty, .head_len, .head_bad
    );

    rx_deliver_ctrl i_rx_deliver_ctrl (
        .RxClk, .rst_n, .status_empty, .head_bad, .credit_return, .head_len,
        .buf_word, .status_pop, .word_pop, .word_valid, .word_last,
        .frame_dropped, .word_data, .frame_bytes
    );

endmodule

// ==== rx_mac/rx_deliver_ctrl.sv ====
// Receive delivery controller
// Pops frame status, sends good frames word by word under consumer
// credit and flushes the words of bad frames from the buffer
`timescale 1ns/1ps

module rx_deliver_ctrl (
    input  logic                                 RxClk,
    input  logic                                 rst_n,
    input  logic                                 status_empty,
    input  logic                                 head_bad,
    input  logic                                 credit_return,
    input  logic [eth_frame_pkg::ETH_LEN_W-1:0]  head_len,
    input  logic [eth_frame_pkg::ETH_WORD_W-1:0] buf_word,
    output logic                                 status_pop,
    output logic                                 word_pop,
    output logic                                 word_valid,
    output logic                                 word_last,
    output logic                                 frame_dropped,
    output logic [eth_frame_pkg::ETH_WORD_W-1:0] word_data,
    output logic [eth_frame_pkg::ETH_LEN_W-1:0]  frame_bytes
);
    import eth_frame_pkg::*;

    deliver_state_t       state;
    logic [CREDIT_W-1:0]  credits;        // Free consumer slots
    logic [CREDIT_W-1:0]  credits_nxt;
    logic [ETH_LEN_W-1:0] words_left;     // Words still to send or drop
    logic [ETH_LEN_W:0]   len_round;      // Byte count plus one, no overflow

    assign len_round  = {1'b0, head_len} + 1'b1;

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign status_pop = (state == IDLE) && !status_empty;
    assign word_valid = (state == DELIVER) && (credits != '0);  // Hold while out of credit
    assign word_last  = word_valid && (words_left == 1);
    assign word_data  = buf_word;
    assign word_pop   = word_valid || ((state == FLUSH) && (words_left != '0));

    // ------------------------------------------------------------------
    // Credit counter
    // ------------------------------------------------------------------
    always_comb begin
        credits_nxt = credits;
        if (word_valid && !credit_return) begin
            credits_nxt = credits - 1'b1;
        end else if (!word_valid && credit_return && (credits != CREDIT_MAX)) begin
            credits_nxt = credits + 1'b1;       // Clamp at the reset value
        end
    end

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            state         <= IDLE;
            credits       <= CREDIT_MAX;
            words_left    <= '0;
            frame_dropped <= 1'b0;
        end else begin
            credits       <= credits_nxt;
            frame_dropped <= 1'b0;
            case (state)
                IDLE: begin
                    if (!status_empty) begin
                        words_left <= len_round[ETH_LEN_W:1];   // Bytes / 2 rounded up
                        // Empty frames have nothing to deliver and count as dropped
                        if (head_bad || (head_len == '0)) begin
                            state         <= FLUSH;
                            frame_dropped <= 1'b1;   // High in the first FLUSH cycle
                        end else begin
                            state <= DELIVER;
                        end
                    end
                end
                DELIVER: begin
                    if (word_valid) begin
                        words_left <= words_left - 1'b1;
                        if (word_last) begin
                            state <= IDLE;
                        end
                    end
                end
                FLUSH: begin
                    if (words_left != '0) begin
                        words_left <= words_left - 1'b1;
                    end
                    if (words_left <= 1) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Length of the frame in flight, presented with word_last
    always_ff @(posedge RxClk) begin
        if (status_pop) begin
            frame_bytes <= head_len;
        end
    end

endmodule

// ==== rx_mac/rx_status_queue.sv ====
// Receive status queue
// One record per frame, the byte count and a combined bad bit,
// held until the controller pops it
`timescale 1ns/1ps

module rx_status_queue (
    input  logic                                RxClk,
    input  logic                                rst_n,
    input  logic                                eof,
    input  logic                                preamble_error,
    input  logic                                phy_error,
    input  logic                                too_long,
    input  logic                                crc_error,
    input  logic                                status_pop,
    input  logic [eth_frame_pkg::ETH_LEN_W-1:0] frame_len,
    output logic                                status_empty,
    output logic [eth_frame_pkg::ETH_LEN_W-1:0] head_len,
    output logic                                head_bad
);
    import eth_frame_pkg::*;

    logic [ETH_LEN_W:0]     mem [STATUS_DEPTH];   // {bad, len}
    logic [STATUS_ADDR_W:0] wr_ptr;               // Extra bit tells full from empty
    logic [STATUS_ADDR_W:0] rd_ptr;
    logic                   frame_bad;

    assign frame_bad = preamble_error | phy_error | too_long | crc_error;

    always_ff @(posedge RxClk) begin
        if (eof) begin
            mem[wr_ptr[STATUS_ADDR_W-1:0]] <= {frame_bad, frame_len};
        end
    end

    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (eof) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (status_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign status_empty         = (wr_ptr == rd_ptr);
    assign {head_bad, head_len} = mem[rd_ptr[STATUS_ADDR_W-1:0]];

endmodule

// ==== rx_mac/rx_word_buffer.sv ====
// Receive word buffer
// Packs frame bytes into 16-bit words, first byte low, pads an odd
// last byte with zero, and stores the words for the controller
`timescale 1ns/1ps

module rx_word_buffer (
    input  logic                                 RxClk,
    input  logic                                 rst_n,
    input  logic                                 byte_valid,
    input  logic                                 eof,
    input  logic                                 word_pop,
    input  logic [eth_frame_pkg::ETH_BYTE_W-1:0] byte_data,
    output logic [eth_frame_pkg::ETH_WORD_W-1:0] buf_word
);
    import eth_frame_pkg::*;

    logic [ETH_WORD_W-1:0]  mem [WORD_BUF_DEPTH];
    logic [WORD_ADDR_W-1:0] wr_ptr;
    logic [WORD_ADDR_W-1:0] rd_ptr;
    logic [ETH_BYTE_W-1:0]  lo_byte;    // Held even byte
    logic                   odd;        // lo_byte waiting for its partner
    logic                   wr_en;
    logic [ETH_WORD_W-1:0]  wr_word;

    // ------------------------------------------------------------------
    // Packing
    // ------------------------------------------------------------------
    assign wr_en   = odd && (byte_valid || eof);
    assign wr_word = byte_valid ? {byte_data, lo_byte}
                                : {{ETH_BYTE_W{1'b0}}, lo_byte};   // Zero pad at eof

    always_ff @(posedge RxClk) begin
        if (byte_valid && !odd) begin
            lo_byte <= byte_data;
        end
    end

    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            odd    <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (byte_valid) begin
                odd <= ~odd;
            end else if (eof) begin
                odd <= 1'b0;                // Next frame starts word aligned
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (word_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    assign buf_word = mem[rd_ptr];   // Visible the cycle after the write

endmodule

// ==== rx_mac/rx_crc32.sv ====
// Receive CRC-32 check
// Runs the CRC over every frame byte, FCS included, and compares
// the register against the fixed residue
`timescale 1ns/1ps

module rx_crc32 (
    input  logic                                 RxClk,
    input  logic                                 rst_n,
    input  logic                                 byte_valid,
    input  logic                                 sof,
    input  logic [eth_frame_pkg::ETH_BYTE_W-1:0] byte_data,
    output logic                                 crc_error
);
    import eth_crc_pkg::*;

    logic [CRC_W-1:0] crc_q;    // Running CRC

    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            crc_q <= CRC_INIT;
        end else if (byte_valid) begin
            // Restart from all ones with the first byte of a frame
            crc_q <= crc32_byte(sof ? CRC_INIT : crc_q, byte_data);
        end
    end

    // Stable from the last byte until the next sof, so valid with eof
    assign crc_error = (crc_q != CRC_RESIDUE);

endmodule

// ==== rx_mac/rx_frame_parser.sv ====
// Receive frame parser
// Checks preamble and SFD, forwards frame bytes one cycle late,
// counts them and collects the per-frame error flags
`timescale 1ns/1ps

module rx_frame_parser (
    input  logic                               RxClk,
    input  logic                               rst_n,
    input  logic                               rx_valid,
    input  logic                               rx_err,
    input  logic [eth_frame_pkg::ETH_BYTE_W-1:0] rx_data,
    output logic                               byte_valid,
    output logic                               sof,
    output logic                               eof,
    output logic                               preamble_error,
    output logic                               phy_error,
    output logic                               too_long,
    output logic [eth_frame_pkg::ETH_BYTE_W-1:0] byte_data,
    output logic [eth_frame_pkg::ETH_LEN_W-1:0]  frame_len
);
    import eth_frame_pkg::*;

    logic       in_frame;   // Past the SFD
    logic [3:0] pre_cnt;    // Preamble bytes seen, saturates

    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            in_frame       <= 1'b0;
            pre_cnt        <= '0;
            byte_valid     <= 1'b0;
            sof            <= 1'b0;
            eof            <= 1'b0;
            preamble_error <= 1'b0;
            phy_error      <= 1'b0;
            too_long       <= 1'b0;
            frame_len      <= '0;
        end else begin
            byte_valid <= 1'b0;
            sof        <= 1'b0;
            eof        <= in_frame && !rx_valid;   // First idle cycle after the frame
            if (!rx_valid) begin
                in_frame <= 1'b0;
                pre_cnt  <= '0;
            end else if (!in_frame) begin
                if (rx_data == ETH_PREAMBLE_BYTE) begin
                    if (pre_cnt != '1) begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end else begin
                    // Any other byte closes the preamble, only a proper SFD is clean
                    in_frame       <= 1'b1;
                    pre_cnt        <= '0;
                    preamble_error <= (rx_data != ETH_SFD_BYTE) ||
                                      (pre_cnt != 4'(ETH_PREAMBLE_LEN));
                    phy_error      <= rx_err;
                    too_long       <= 1'b0;
                    frame_len      <= '0;
                end
            end else begin
                byte_valid <= 1'b1;
                sof        <= (frame_len == '0);          // First data byte
                frame_len  <= frame_len + 1'b1;
                phy_error  <= phy_error | rx_err;         // Sticky for the frame
                if (frame_len >= ETH_MAX_FRAME_BYTES) begin
                    too_long <= 1'b1;
                end
            end
        end
    end

    // Byte pipeline register
    always_ff @(posedge RxClk) begin
        if (rx_valid && in_frame) begin
            byte_data <= rx_data;
        end
    end

endmodule

// ==== common/eth_crc_pkg.sv ====
// Ethernet CRC-32 definitions
// Register runs MSB first, each byte is fed LSB first (bit-reversed)
package eth_crc_pkg;

    localparam int CRC_W = 32;
    localparam logic [CRC_W-1:0] CRC_POLY    = 32'h04C1_1DB7;  // IEEE 802.3
    localparam logic [CRC_W-1:0] CRC_INIT    = '1;
    // Left in the register after data plus a correct FCS
    localparam logic [CRC_W-1:0] CRC_RESIDUE = 32'hC704_DD7B;

    // Advance the CRC by one byte, bit 0 of the byte goes in first
    function automatic logic [CRC_W-1:0] crc32_byte(input logic [CRC_W-1:0] crc_in,
                                                    input logic [7:0]       data);
        logic [CRC_W-1:0] crc;
        logic             fb;
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            fb  = crc[CRC_W-1] ^ data[i];    // Feedback tap
            crc = {crc[CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
        return crc;
    endfunction

endpackage

// ==== common/eth_frame_pkg.sv ====
// Ethernet receive frame definitions
// Byte and word widths, frame limits, buffer sizing and controller states
package eth_frame_pkg;

    // ------------------------------------------------------------------
    // Data path widths
    // ------------------------------------------------------------------
    localparam int ETH_BYTE_W = 8;             // GMII byte
    localparam int ETH_WORD_W = 16;            // Delivered word, two bytes
    localparam int ETH_LEN_W  = 12;            // Frame byte count

    // ------------------------------------------------------------------
    // Frame format
    // ------------------------------------------------------------------
    localparam logic [ETH_BYTE_W-1:0] ETH_PREAMBLE_BYTE = 8'h55;
    localparam logic [ETH_BYTE_W-1:0] ETH_SFD_BYTE      = 8'hD5;
    localparam int ETH_PREAMBLE_LEN = 7;       // 0x55 bytes ahead of the SFD

    // Longest accepted frame, FCS included
    localparam logic [ETH_LEN_W-1:0] ETH_MAX_FRAME_BYTES = 12'd1518;

    // ------------------------------------------------------------------
    // Buffer sizing and flow control
    // ------------------------------------------------------------------
    localparam int WORD_BUF_DEPTH = 2048;      // 4 KB of frame data
    localparam int WORD_ADDR_W    = $clog2(WORD_BUF_DEPTH);
    localparam int STATUS_DEPTH   = 8;         // Frames waiting for the controller
    localparam int STATUS_ADDR_W  = $clog2(STATUS_DEPTH);

    localparam int CREDIT_W = 3;
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = 3'd4;   // Consumer slots after reset

    // Delivery controller states
    typedef enum logic [1:0] {
        IDLE,       // Waiting for a status record
        DELIVER,    // Sending a good frame to the consumer
        FLUSH       // Discarding the words of a bad frame
    } deliver_state_t;

endpackage
